//--- source/box_pkg.sv
package box_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Image geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int COLS = 15;
  localparam int ROWS = 4;
  localparam int WIN = 13;

  // Word widths
  localparam int PIX_W = 8;
  localparam int SUM_W = 12;
  localparam int COL_W = 4;
  localparam int ROW_W = 2;

  // Wait after frame_ready before the first row
  localparam int SETTLE = 3;
  localparam int SET_W = 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequencer states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_settle    = 3'd1,
    st_start_row = 3'd2,
    st_fill      = 3'd3,
    st_slide     = 3'd4,
    st_finish    = 3'd5
  } seq_state_t;

endpackage

//--- source/box_if.sv
// Strobes from the row sequencer
interface seq_ctrl_if ();

  logic settle_en;
  logic ld_en;
  logic count_en;
  logic sum_en;
  logic cum_en;
  logic clear_en;
  logic frame_end;

  modport decode (
    output settle_en, ld_en, count_en, sum_en, cum_en, clear_en, frame_end
  );

  modport execute (
    input settle_en, ld_en, count_en, sum_en, cum_en, clear_en
  );

  // Result stage only needs the slide strobe and the frame end
  modport result (
    input cum_en, frame_end
  );

endinterface

// Datapath status back to the sequencer
interface dp_status_if import box_pkg::*; ();

  logic             settle_done;
  logic [COL_W-1:0] col;
  logic [ROW_W-1:0] row;
  logic             last_row;

  modport datapath (output settle_done, col, row, last_row);

  modport sequencer (input settle_done, col, last_row);

endinterface

//--- source/row_sequencer.sv
module row_sequencer import box_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           frame_ready,
  seq_ctrl_if.decode     ctrl,
  dp_status_if.sequencer status
);

  seq_state_t state;
  seq_state_t next_state;
  logic       fill_done;
  logic       row_done;

  assign fill_done = (status.col == COL_W'(WIN - 1));
  assign row_done  = (status.col == COL_W'(COLS - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // Next state
  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (frame_ready) begin
          next_state = st_settle;
        end
      end
      st_settle: begin
        if (status.settle_done) begin
          next_state = st_start_row;
        end
      end
      st_start_row: next_state = st_fill;
      st_fill: begin
        if (fill_done) begin
          next_state = st_slide;
        end
      end
      st_slide: begin
        // Row ends on the last column, frame ends on the last row
        if (row_done) begin
          next_state = status.last_row ? st_finish : st_start_row;
        end
      end
      st_finish: next_state = st_idle;
      default: next_state = st_idle;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Strobe decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    ctrl.settle_en = 1'b0;
    ctrl.ld_en     = 1'b0;
    ctrl.count_en  = 1'b0;
    ctrl.sum_en    = 1'b0;
    ctrl.cum_en    = 1'b0;
    ctrl.clear_en  = 1'b0;
    ctrl.frame_end = 1'b0;
    case (state)
      st_settle: ctrl.settle_en = 1'b1;
      st_start_row: begin
        ctrl.ld_en    = 1'b1;
        ctrl.count_en = 1'b1;
      end
      st_fill: begin
        ctrl.count_en = 1'b1;
        ctrl.sum_en   = 1'b1;
      end
      st_slide: begin
        ctrl.count_en = 1'b1;
        ctrl.sum_en   = 1'b1;
        ctrl.cum_en   = 1'b1;
      end
      st_finish: begin
        ctrl.frame_end = 1'b1;
        ctrl.clear_en  = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- source/window_datapath.sv
module window_datapath import box_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  seq_ctrl_if.execute      ctrl,
  dp_status_if.datapath    status,
  input  logic [PIX_W-1:0] pix_data,
  output logic [ROW_W-1:0] pix_row,
  output logic [COL_W-1:0] pix_col,
  output logic [SUM_W-1:0] acc,
  output logic [ROW_W-1:0] acc_row,
  output logic [COL_W-1:0] acc_col
);

  logic [SET_W-1:0] settle_cnt;
  logic [PIX_W-1:0] delay_line [WIN];
  logic [SUM_W-1:0] acc_base;
  logic [SUM_W-1:0] add_term;
  logic [SUM_W-1:0] sub_term;
  logic             row_end;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Settle counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      settle_cnt <= '0;
    end else if (ctrl.settle_en) begin
      settle_cnt <= settle_cnt + 1'b1;
    end else begin
      settle_cnt <= '0;
    end
  end

  assign status.settle_done = ctrl.settle_en && (settle_cnt == SET_W'(SETTLE - 1));

  // Column and row counters double as the pixel address
  assign row_end = ctrl.count_en && (status.col == COL_W'(COLS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status.col <= '0;
      status.row <= '0;
    end else if (ctrl.clear_en) begin
      status.col <= '0;
      status.row <= '0;
    end else if (row_end) begin
      status.col <= '0;
      status.row <= status.row + 1'b1;
    end else if (ctrl.count_en) begin
      status.col <= status.col + 1'b1;
    end
  end

  assign status.last_row = (status.row == ROW_W'(ROWS - 1));
  assign pix_row         = status.row;
  assign pix_col         = status.col;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Window accumulator
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tap WIN-1 holds the pixel that leaves the window
  always_ff @(posedge clk) begin
    if (ctrl.count_en) begin
      delay_line[0] <= pix_data;
      for (int i = 1; i < WIN; i++) begin
        delay_line[i] <= delay_line[i-1];
      end
    end
  end

  assign acc_base = ctrl.ld_en ? '0 : acc;
  assign add_term = SUM_W'(pix_data);
  assign sub_term = ctrl.cum_en ? SUM_W'(delay_line[WIN-1]) : '0;

  always_ff @(posedge clk) begin
    if (ctrl.ld_en || ctrl.sum_en) begin
      acc     <= acc_base + add_term - sub_term;
      acc_row <= status.row;
      acc_col <= status.col;
    end
  end

endmodule

//--- source/sum_result.sv
module sum_result import box_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  seq_ctrl_if.result       ctrl,
  input  logic [SUM_W-1:0] acc,
  input  logic [ROW_W-1:0] acc_row,
  input  logic [COL_W-1:0] acc_col,
  output logic [SUM_W-1:0] sum_data,
  output logic [ROW_W-1:0] sum_row,
  output logic [COL_W-1:0] sum_col,
  output logic             sum_valid,
  output logic             frame_done
);

  logic win_full;
  logic take;

  // Accumulator holds a full window during each slide cycle
  // and in the cycle right after the last one
  assign take = ctrl.cum_en || win_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_full   <= 1'b0;
      sum_valid  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      win_full   <= ctrl.cum_en;
      sum_valid  <= take;
      frame_done <= ctrl.frame_end;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sum and tag capture
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (take) begin
      sum_data <= acc;
      sum_row  <= acc_row;
      sum_col  <= acc_col;
    end
  end

endmodule

//--- source/box_row_top.sv
module box_row_top import box_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             frame_ready,
  output logic [ROW_W-1:0] pix_row,
  output logic [COL_W-1:0] pix_col,
  input  logic [PIX_W-1:0] pix_data,
  output logic [SUM_W-1:0] sum_data,
  output logic [ROW_W-1:0] sum_row,
  output logic [COL_W-1:0] sum_col,
  output logic             sum_valid,
  output logic             frame_done
);

  logic [SUM_W-1:0] acc;
  logic [ROW_W-1:0] acc_row;
  logic [COL_W-1:0] acc_col;

  seq_ctrl_if  u_ctrl ();
  dp_status_if u_status ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode, execute, result
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  row_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_ready (frame_ready),
    .ctrl        (u_ctrl),
    .status      (u_status)
  );

  window_datapath u_dp (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (u_ctrl),
    .status   (u_status),
    .pix_data (pix_data),
    .pix_row  (pix_row),
    .pix_col  (pix_col),
    .acc      (acc),
    .acc_row  (acc_row),
    .acc_col  (acc_col)
  );

  sum_result u_res (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (u_ctrl),
    .acc        (acc),
    .acc_row    (acc_row),
    .acc_col    (acc_col),
    .sum_data   (sum_data),
    .sum_row    (sum_row),
    .sum_col    (sum_col),
    .sum_valid  (sum_valid),
    .frame_done (frame_done)
  );

endmodule

//--- test/box_row_chk.sv
module box_row_chk import box_pkg::*; (
  input logic             clk,
  input logic             rst_n,
  input logic             frame_ready,
  input logic [ROW_W-1:0] pix_row,
  input logic [COL_W-1:0] pix_col,
  input logic [PIX_W-1:0] pix_data,
  input logic [SUM_W-1:0] sum_data,
  input logic [ROW_W-1:0] sum_row,
  input logic [COL_W-1:0] sum_col,
  input logic             sum_valid,
  input logic             frame_done,
  input seq_state_t       state
);

  timeunit 1ns;
  timeprecision 100ps;

  int               err_count = 0;
  logic [PIX_W-1:0] shadow [ROWS][COLS];
  logic [SUM_W-1:0] exp_sum;
  logic [COL_W-1:0] exp_col;
  logic [ROW_W-1:0] exp_row;
  logic [COL_W-1:0] exp_pix_col;
  logic [ROW_W-1:0] exp_pix_row;
  logic             quiet;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shadow of consumed pixels
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (state inside {st_start_row, st_fill, st_slide}) begin
      shadow[pix_row][pix_col] <= pix_data;
    end
  end

  // Expected pixel address, one column per row cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pix_col <= '0;
      exp_pix_row <= '0;
    end else if (state inside {st_start_row, st_fill, st_slide}) begin
      if (exp_pix_col == COL_W'(COLS - 1)) begin
        exp_pix_col <= '0;
        exp_pix_row <= (exp_pix_row == ROW_W'(ROWS - 1)) ? '0 : exp_pix_row + 1'b1;
      end else begin
        exp_pix_col <= exp_pix_col + 1'b1;
      end
    end
  end

  // Window ending at sum_col
  always_comb begin
    int idx;
    exp_sum = '0;
    for (int i = 0; i < WIN; i++) begin
      idx = int'(sum_col) - i;
      if (idx >= 0) begin
        exp_sum = exp_sum + SUM_W'(shadow[sum_row][idx]);
      end
    end
  end

  // Expected tag order, columns WIN-1 up to COLS-1 in each row
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_col <= COL_W'(WIN - 1);
      exp_row <= '0;
    end else if (sum_valid) begin
      if (exp_col == COL_W'(COLS - 1)) begin
        exp_col <= COL_W'(WIN - 1);
        exp_row <= (exp_row == ROW_W'(ROWS - 1)) ? '0 : exp_row + 1'b1;
      end else begin
        exp_col <= exp_col + 1'b1;
      end
    end
  end

  // High from reset or frame end until a frame is accepted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quiet <= 1'b1;
    end else if (frame_ready && state == st_idle) begin
      quiet <= 1'b0;
    end else if (frame_done) begin
      quiet <= 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Assertions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_sum_value: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid |-> sum_data == exp_sum)
    else begin
      err_count++;
      $error("ERR sum_data exp %h got %h", $sampled(exp_sum), $sampled(sum_data));
    end

  a_sum_col: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid |-> sum_col == exp_col)
    else begin
      err_count++;
      $error("ERR sum_col exp %h got %h", $sampled(exp_col), $sampled(sum_col));
    end

  a_sum_row: assert property (@(posedge clk) disable iff (!rst_n)
    sum_valid |-> sum_row == exp_row)
    else begin
      err_count++;
      $error("ERR sum_row exp %h got %h", $sampled(exp_row), $sampled(sum_row));
    end

  a_pix_addr: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {st_start_row, st_fill, st_slide} |->
      pix_row == exp_pix_row && pix_col == exp_pix_col)
    else begin
      err_count++;
      $error("ERR pix_row/pix_col exp %h/%h got %h/%h",
             $sampled(exp_pix_row), $sampled(exp_pix_col),
             $sampled(pix_row), $sampled(pix_col));
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    state == st_finish |=> frame_done ##1 !frame_done)
    else begin
      err_count++;
      $error("frame_done did not pulse once after the finish state");
    end

  // Last sum of the frame leaves together with frame_done
  a_done_last_sum: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |-> sum_valid && sum_row == ROW_W'(ROWS - 1) && sum_col == COL_W'(COLS - 1))
    else begin
      err_count++;
      $error("frame_done came without the last sum of the frame");
    end

  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    quiet |-> !sum_valid && !frame_done)
    else begin
      err_count++;
      $error("Output strobe seen while no frame was requested");
    end

endmodule

bind box_row_top box_row_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .frame_ready (frame_ready),
  .pix_row     (pix_row),
  .pix_col     (pix_col),
  .pix_data    (pix_data),
  .sum_data    (sum_data),
  .sum_row     (sum_row),
  .sum_col     (sum_col),
  .sum_valid   (sum_valid),
  .frame_done  (frame_done),
  .state       (u_seq.state)
);

//--- test/box_row_tb.sv
module box_row_tb import box_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic             clk;
  logic             rst_n;
  logic             frame_ready;
  logic [ROW_W-1:0] pix_row;
  logic [COL_W-1:0] pix_col;
  logic [PIX_W-1:0] pix_data;
  logic [SUM_W-1:0] sum_data;
  logic [ROW_W-1:0] sum_row;
  logic [COL_W-1:0] sum_col;
  logic             sum_valid;
  logic             frame_done;

  logic [PIX_W-1:0] pix_mem [ROWS][COLS];
  logic [31:0]      lfsr_state;
  int               sum_count = 0;
  int               frame_count = 0;
  int               tb_errors = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock and DUT
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial clk = 1'b0;
  always #10 clk = ~clk;

  box_row_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_ready (frame_ready),
    .pix_row     (pix_row),
    .pix_col     (pix_col),
    .pix_data    (pix_data),
    .sum_data    (sum_data),
    .sum_row     (sum_row),
    .sum_col     (sum_col),
    .sum_valid   (sum_valid),
    .frame_done  (frame_done)
  );

  // Pixel memory, combinational read
  assign pix_data = pix_mem[pix_row][pix_col];

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic load_frame_pixels();
    logic [PIX_W-1:0] pix;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        for (int b = 0; b < PIX_W; b++) begin
          lfsr_state = next_lfsr(lfsr_state);
          pix[b]     = lfsr_state[0];
        end
        pix_mem[r][c] = pix;
      end
    end
  endtask

  task automatic wait_frame_done();
    do begin
      @(negedge clk);
    end while (!frame_done);
  endtask

  // Tally of output strobes
  always @(negedge clk) begin
    if (rst_n && sum_valid) begin
      sum_count++;
    end
    if (rst_n && frame_done) begin
      frame_count++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int sums_expected;
    rst_n         = 1'b0;
    frame_ready   = 1'b0;
    lfsr_state    = 32'd79106;
    sums_expected = 3 * ROWS * (COLS - WIN + 1);
    load_frame_pixels();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Outputs must stay low here
    repeat (6) @(posedge clk);
    frame_ready <= 1'b1;

    // Held high through frame 1, so frame 2 follows at once
    wait_frame_done();
    load_frame_pixels();
    @(posedge clk);
    frame_ready <= 1'b0;
    wait_frame_done();
    load_frame_pixels();

    // Gap with frame_ready low, then a single-cycle request
    repeat (8) @(posedge clk);
    frame_ready <= 1'b1;
    @(posedge clk);
    frame_ready <= 1'b0;
    wait_frame_done();
    repeat (4) @(posedge clk);

    if (sum_count != sums_expected) begin
      tb_errors++;
      $display("ERR sum_valid count exp %h got %h", sums_expected, sum_count);
    end
    if (frame_count != 3) begin
      tb_errors++;
      $display("ERR frame_done count exp %h got %h", 3, frame_count);
    end

    $display("Checker errors %0d, testbench errors %0d, sums %0d, frames %0d",
             u_dut.u_chk.err_count, tb_errors, sum_count, frame_count);
    if (u_dut.u_chk.err_count == 0 && tb_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Three frames plus margin
  initial begin
    int limit;
    limit = 3 * (SETTLE + ROWS * COLS + 4) * 3 / 2;
    repeat (limit) @(posedge clk);
    $display("Run timed out after %0d cycles with %0d of 3 frames done",
             limit, frame_count);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- list.f
source/box_pkg.sv
source/box_if.sv
source/row_sequencer.sv
source/window_datapath.sv
source/sum_result.sv
source/box_row_top.sv
test/box_row_chk.sv
test/box_row_tb.sv
